//--- hw/alu_exec.sv
`timescale 1ns/100ps

module alu_exec (
	input  rv64_pkg::xlen_t   ra_data,
	input  rv64_pkg::xlen_t   rb_data,
	input  rv64_pkg::xlen_t   imm,
	input  rv64_pkg::xlen_t   pc_out,
	input  rv64_pkg::alu_op_t alu_op,
	input  logic              alu_src,
	input  logic              pc_to_a,
	output rv64_pkg::xlen_t   alu_out,
	output logic              alu_zero,
	output logic              alu_less
);
	import rv64_pkg::*;

	xlen_t      op_a;
	xlen_t      op_b;
	xlen_t      sum;
	xlen_t      diff;
	logic [5:0] shamt;

	assign op_a  = pc_to_a ? pc_out : ra_data;
	assign op_b  = alu_src ? imm : rb_data;
	assign sum   = op_a + op_b;
	assign diff  = op_a - op_b;
	assign shamt = op_b[5:0]; // RV64 shift amount

	// Signed compare, shared by SLT and BLT
	assign alu_less = $signed(op_a) < $signed(op_b);

	always_comb begin
		case (alu_op)
			alu_add:    alu_out = sum;
			alu_sub:    alu_out = diff;
			alu_and:    alu_out = op_a & op_b;
			alu_or:     alu_out = op_a | op_b;
			alu_xor:    alu_out = op_a ^ op_b;
			alu_sll:    alu_out = op_a << shamt;
			alu_srl:    alu_out = op_a >> shamt;
			alu_slt:    alu_out = {63'b0, alu_less};
			alu_pass_b: alu_out = op_b;
			default:    alu_out = sum;
		endcase
	end

	assign alu_zero = (alu_out == '0);

endmodule

//--- hw/data_mem.sv
`timescale 1ns/100ps

module data_mem (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv64_pkg::mem_index_t addr,
	input  rv64_pkg::xlen_t      write_data,
	input  logic                 mem_write,
	output rv64_pkg::xlen_t      mem_data
);
	import rv64_pkg::*;

	xlen_t mem [mem_depth];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (mem_write) begin
			mem[addr] <= write_data;
		end
	end

	assign mem_data = mem[addr]; // Combinational read for LD

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
	input  rv64_pkg::instr_t    inst,
	output rv64_pkg::reg_addr_t ra,
	output rv64_pkg::reg_addr_t rb,
	output rv64_pkg::reg_addr_t rw,
	output rv64_pkg::xlen_t     imm,
	output rv64_pkg::alu_op_t   alu_op,
	output logic                alu_src,
	output logic                pc_to_a,
	output logic                reg_write,
	output logic                mem_write,
	output logic                branch,
	output logic [1:0]          branch_kind,
	output logic                jump,
	output rv64_pkg::wb_sel_t   wb_sel
);
	import rv64_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_b;
	xlen_t      imm_u;
	xlen_t      imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign ra = inst[19:15];
	assign rb = inst[24:20];
	assign rw = inst[11:7];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		imm         = imm_i;
		alu_op      = alu_add;
		alu_src     = 1'b0;
		pc_to_a     = 1'b0;
		reg_write   = 1'b0;
		mem_write   = 1'b0;
		branch      = 1'b0;
		branch_kind = br_eq;
		jump        = 1'b0;
		wb_sel      = wb_alu;
		case (opcode)
			op_imm: begin
				alu_src   = 1'b1;
				reg_write = 1'b1;
				case (funct3)
					3'b000:  alu_op = alu_add;
					3'b100:  alu_op = alu_xor;
					3'b110:  alu_op = alu_or;
					3'b111:  alu_op = alu_and;
					default: reg_write = 1'b0; // Unsupported immediate op
				endcase
			end
			op_reg: begin
				reg_write = 1'b1;
				case (funct3)
					3'b000:  alu_op = (funct7 == 7'b0100000) ? alu_sub : alu_add;
					3'b001:  alu_op = alu_sll;
					3'b010:  alu_op = alu_slt;
					3'b100:  alu_op = alu_xor;
					3'b101:  alu_op = alu_srl;
					3'b110:  alu_op = alu_or;
					default: alu_op = alu_and; // funct3 111
				endcase
			end
			op_lui: begin
				imm       = imm_u;
				alu_src   = 1'b1;
				alu_op    = alu_pass_b;
				reg_write = 1'b1;
			end
			op_load: begin
				alu_src   = 1'b1; // Address is rs1 + imm
				reg_write = 1'b1;
				wb_sel    = wb_mem;
			end
			op_store: begin
				imm       = imm_s;
				alu_src   = 1'b1;
				mem_write = 1'b1;
			end
			op_branch: begin
				imm    = imm_b;
				alu_op = alu_sub; // Flags compare rs1 with rs2
				case (funct3)
					3'b000:  begin branch = 1'b1; branch_kind = br_eq; end
					3'b001:  begin branch = 1'b1; branch_kind = br_ne; end
					3'b100:  begin branch = 1'b1; branch_kind = br_lt; end
					default: branch = 1'b0;
				endcase
			end
			op_jal: begin
				imm       = imm_j;
				pc_to_a   = 1'b1; // Target = pc + imm through the ALU
				alu_src   = 1'b1;
				jump      = 1'b1;
				reg_write = 1'b1;
				wb_sel    = wb_pc4;
			end
			default: ; // Unknown opcode behaves as a no-op
		endcase
	end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  rv64_pkg::reg_addr_t ra,
	input  rv64_pkg::reg_addr_t rb,
	input  rv64_pkg::reg_addr_t rw,
	input  rv64_pkg::xlen_t     rw_data,
	input  logic                reg_write,
	output rv64_pkg::xlen_t     ra_data,
	output rv64_pkg::xlen_t     rb_data
);
	import rv64_pkg::*;

	xlen_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write && rw != '0) begin
			regs[rw] <= rw_data;
		end
	end

	assign ra_data = (ra == '0) ? '0 : regs[ra];
	assign rb_data = (rb == '0) ? '0 : regs[rb];

endmodule

//--- hw/result_select.sv
`timescale 1ns/100ps

module result_select (
	input  logic              clk,
	input  logic              rst_n,
	input  rv64_pkg::xlen_t   alu_out,
	input  rv64_pkg::xlen_t   mem_data,
	input  rv64_pkg::xlen_t   imm,
	input  rv64_pkg::wb_sel_t wb_sel,
	input  logic              alu_zero,
	input  logic              alu_less,
	input  logic              branch,
	input  logic              jump,
	input  logic [1:0]        branch_kind,
	output rv64_pkg::xlen_t   rw_data,
	output rv64_pkg::xlen_t   pc_out
);
	import rv64_pkg::*;

	xlen_t pc_plus4;
	xlen_t branch_target; // Own adder, the ALU is doing the compare
	xlen_t next_pc;
	logic  taken;

	assign pc_plus4      = pc_out + 64'd4;
	assign branch_target = pc_out + imm;

	always_comb begin
		case (wb_sel)
			wb_mem:  rw_data = mem_data;
			wb_pc4:  rw_data = pc_plus4; // Link value for JAL
			default: rw_data = alu_out;
		endcase
	end

	always_comb begin
		case (branch_kind)
			br_eq:   taken = branch & alu_zero;
			br_ne:   taken = branch & ~alu_zero;
			br_lt:   taken = branch & alu_less;
			default: taken = 1'b0;
		endcase
	end

	assign next_pc = jump ? alu_out : (taken ? branch_target : pc_plus4);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_out <= reset_pc;
		end else begin
			pc_out <= next_pc;
		end
	end

endmodule

//--- hw/rv64_core.sv
`timescale 1ns/100ps

module rv64_core (
	input  logic             clk,
	input  logic             rst_n,
	input  rv64_pkg::instr_t inst,
	output rv64_pkg::xlen_t  alu_out,
	output rv64_pkg::xlen_t  pc_out
);
	import rv64_pkg::*;

	reg_addr_t  ra;
	reg_addr_t  rb;
	reg_addr_t  rw;
	xlen_t      imm;
	alu_op_t    alu_op;
	logic       alu_src;
	logic       pc_to_a;
	logic       reg_write;
	logic       mem_write;
	logic       branch;
	logic [1:0] branch_kind;
	logic       jump;
	wb_sel_t    wb_sel;
	xlen_t      ra_data;
	xlen_t      rb_data;
	xlen_t      rw_data;
	xlen_t      mem_data;
	logic       alu_zero;
	logic       alu_less;

	instr_decode instr_decode_inst (
		.inst        (inst),
		.ra          (ra),
		.rb          (rb),
		.rw          (rw),
		.imm         (imm),
		.alu_op      (alu_op),
		.alu_src     (alu_src),
		.pc_to_a     (pc_to_a),
		.reg_write   (reg_write),
		.mem_write   (mem_write),
		.branch      (branch),
		.branch_kind (branch_kind),
		.jump        (jump),
		.wb_sel      (wb_sel)
	);

	reg_file reg_file_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ra        (ra),
		.rb        (rb),
		.rw        (rw),
		.rw_data   (rw_data),
		.reg_write (reg_write),
		.ra_data   (ra_data),
		.rb_data   (rb_data)
	);

	alu_exec alu_exec_inst (
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.imm      (imm),
		.pc_out   (pc_out),
		.alu_op   (alu_op),
		.alu_src  (alu_src),
		.pc_to_a  (pc_to_a),
		.alu_out  (alu_out),
		.alu_zero (alu_zero),
		.alu_less (alu_less)
	);

	data_mem data_mem_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (alu_out[8:3]), // Doubleword index
		.write_data (rb_data),
		.mem_write  (mem_write),
		.mem_data   (mem_data)
	);

	result_select result_select_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.alu_out     (alu_out),
		.mem_data    (mem_data),
		.imm         (imm),
		.wb_sel      (wb_sel),
		.alu_zero    (alu_zero),
		.alu_less    (alu_less),
		.branch      (branch),
		.jump        (jump),
		.branch_kind (branch_kind),
		.rw_data     (rw_data),
		.pc_out      (pc_out)
	);

endmodule

//--- hw/rv64_pkg.sv
package rv64_pkg;

	typedef logic [63:0] xlen_t;      // Data and address word
	typedef logic [31:0] instr_t;     // Raw instruction
	typedef logic [4:0]  reg_addr_t;  // GPR index
	typedef logic [5:0]  mem_index_t; // Doubleword index into data memory

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_slt,
		alu_pass_b // LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc4
	} wb_sel_t;

	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	// Branch kinds passed from decode to the PC logic
	localparam logic [1:0] br_eq = 2'd0;
	localparam logic [1:0] br_ne = 2'd1;
	localparam logic [1:0] br_lt = 2'd2;

	localparam xlen_t reset_pc  = 64'h0;
	localparam int    mem_depth = 64;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rv64_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f rv64_core.f --top-module rv64_core_tb -o rv64_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rv64_core_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- rv64_core.f
hw/rv64_pkg.sv
hw/instr_decode.sv
hw/alu_exec.sv
hw/reg_file.sv
hw/data_mem.sv
hw/result_select.sv
hw/rv64_core.sv
verif/rv64_core_tb.sv

//--- verif/rv64_core_tb.sv
`timescale 1ns/100ps

module rv64_core_tb;
	import rv64_pkg::*;

	logic   clk;
	logic   rst_n;
	instr_t inst;
	xlen_t  alu_out;
	xlen_t  pc_out;

	int     seed;
	xlen_t  regs_m [32]; // Reference register state
	xlen_t  pc_m;        // Reference PC

	rv64_core rv64_core_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.inst    (inst),
		.alu_out (alu_out),
		.pc_out  (pc_out)
	);

	always #50 clk = ~clk;

	function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic instr_t b_type(input logic [12:0] off, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd);
		return {imm, rd, op_lui};
	endfunction

	function automatic instr_t j_type(input logic [20:0] off, input reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	function automatic xlen_t sext12(input logic [11:0] v);
		return {{52{v[11]}}, v};
	endfunction

	task automatic check(input string name, input xlen_t act, input xlen_t exp);
		if (act !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic wait_fall();
		logic prev;
		int   steps;
		prev  = clk;
		steps = 0;
		while (!(prev === 1'b1 && clk === 1'b0) && steps < 500) begin
			prev = clk;
			#1;
			steps++;
		end
		if (!(prev === 1'b1 && clk === 1'b0)) begin
			$display("Timed out waiting for a falling clock edge");
			$display("Some tests failed");
			$fatal(1, "Clock stalled");
		end
	endtask

	// Drive one instruction, check before the rising edge, then advance the model
	task automatic run_instr(input instr_t i, input logic chk_alu, input xlen_t exp_alu,
		input reg_addr_t rd, input xlen_t rd_val, input xlen_t next_pc);
		wait_fall();
		inst = i;
		#40;
		check("pc_out", pc_out, pc_m);
		if (chk_alu) begin
			check("alu_out", alu_out, exp_alu);
		end
		pc_m = next_pc;
		if (rd != 5'd0) begin
			regs_m[rd] = rd_val; // x0 writes are dropped
		end
	endtask

	task automatic do_alu(input instr_t i, input reg_addr_t rd, input xlen_t val);
		run_instr(i, 1'b1, val, rd, val, pc_m + 64'd4);
	endtask

	task automatic read_reg(input reg_addr_t rs);
		run_instr(r_type(7'd0, 5'd0, rs, 3'b000, 5'd0), 1'b1, regs_m[rs], 5'd0, 64'd0,
			pc_m + 64'd4); // ADD x0, rs, x0
	endtask

	task automatic load_val(input reg_addr_t rd, input logic [31:0] v);
		logic [19:0] hi;
		xlen_t       up;
		hi = v[31:12] + {19'd0, v[11]}; // Undo the sign of the low part
		up = {{32{hi[19]}}, hi, 12'd0};
		do_alu(u_type(hi, rd), rd, up);
		do_alu(i_type(v[11:0], rd, 3'b000, rd, op_imm), rd, up + sext12(v[11:0]));
	endtask

	task automatic branch_step(input logic [2:0] f3, input reg_addr_t rs1,
		input reg_addr_t rs2, input logic [12:0] off, input logic taken);
		xlen_t next_pc;
		next_pc = taken ? pc_m + {{51{off[12]}}, off} : pc_m + 64'd4;
		run_instr(b_type(off, rs2, rs1, f3), 1'b1, regs_m[rs1] - regs_m[rs2], 5'd0, 64'd0,
			next_pc);
	endtask

	task automatic reset_and_release();
		for (int c = 0; c < 15; c++) begin
			wait_fall();
			#40;
			check("pc_out", pc_out, reset_pc);
		end
		wait_fall();
		rst_n = 1'b1;
		inst  = 32'h0000_007f; // Unknown opcode in the first cycle
		#40;
		check("pc_out", pc_out, reset_pc);
		pc_m = reset_pc + 64'd4;
	endtask

	task automatic pc_sequence();
		logic [31:0] r;
		for (int n = 0; n < 3; n++) begin
			r = $random(seed);
			load_val(5'd5, r);
			run_instr({r[31:12], 5'd5, 7'h7f}, 1'b0, 64'd0, 5'd0, 64'd0, pc_m + 64'd4);
			read_reg(5'd5); // Unchanged by the unknown opcode
		end
	endtask

	task automatic add_sub_ops();
		logic [31:0] a;
		logic [31:0] b;
		for (int n = 0; n < 6; n++) begin
			a = $random(seed);
			b = $random(seed);
			do_alu(i_type(a[11:0], 5'd0, 3'b000, 5'd1, op_imm), 5'd1, sext12(a[11:0]));
			do_alu(i_type(b[11:0], 5'd1, 3'b000, 5'd2, op_imm), 5'd2,
				regs_m[1] + sext12(b[11:0]));
			do_alu(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, regs_m[1] + regs_m[2]);
			do_alu(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, regs_m[1] - regs_m[2]);
			do_alu(i_type(a[11:0], 5'd2, 3'b000, 5'd0, op_imm), 5'd0,
				regs_m[2] + sext12(a[11:0])); // Sum shows, write to x0 dropped
			run_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd0), 1'b1, 64'd0, 5'd0, 64'd0,
				pc_m + 64'd4);
		end
	endtask

	task automatic logic_shift_ops();
		logic [31:0] r;
		for (int n = 0; n < 4; n++) begin
			load_val(5'd1, $random(seed));
			load_val(5'd2, $random(seed));
			do_alu(r_type(7'd0, 5'd2, 5'd1, 3'b001, 5'd1), 5'd1,
				regs_m[1] << regs_m[2][5:0]); // Spread x1 over 64 bits
			do_alu(r_type(7'd0, 5'd2, 5'd1, 3'b111, 5'd3), 5'd3, regs_m[1] & regs_m[2]);
			do_alu(r_type(7'd0, 5'd2, 5'd1, 3'b110, 5'd4), 5'd4, regs_m[1] | regs_m[2]);
			do_alu(r_type(7'd0, 5'd2, 5'd1, 3'b100, 5'd5), 5'd5, regs_m[1] ^ regs_m[2]);
			do_alu(r_type(7'd0, 5'd2, 5'd1, 3'b101, 5'd6), 5'd6,
				regs_m[1] >> regs_m[2][5:0]);
			do_alu(r_type(7'd0, 5'd2, 5'd1, 3'b010, 5'd7), 5'd7,
				{63'd0, $signed(regs_m[1]) < $signed(regs_m[2])});
			do_alu(r_type(7'd0, 5'd1, 5'd2, 3'b010, 5'd7), 5'd7,
				{63'd0, $signed(regs_m[2]) < $signed(regs_m[1])});
			r = $random(seed);
			do_alu(i_type(r[11:0], 5'd1, 3'b111, 5'd8, op_imm), 5'd8,
				regs_m[1] & sext12(r[11:0]));
			do_alu(i_type(r[23:12], 5'd1, 3'b110, 5'd8, op_imm), 5'd8,
				regs_m[1] | sext12(r[23:12]));
			do_alu(i_type(r[31:20], 5'd1, 3'b100, 5'd8, op_imm), 5'd8,
				regs_m[1] ^ sext12(r[31:20]));
			do_alu(u_type(r[19:0], 5'd9), 5'd9, {{32{r[19]}}, r[19:0], 12'd0});
		end
	endtask

	task automatic load_store_pair();
		logic [31:0] r;
		xlen_t       stored;
		for (int n = 0; n < 4; n++) begin
			load_val(5'd1, $random(seed));
			r = $random(seed);
			do_alu(i_type({3'd0, r[5:0], 3'd0}, 5'd0, 3'b000, 5'd2, op_imm), 5'd2,
				{55'd0, r[5:0], 3'd0}); // Doubleword aligned base
			stored = regs_m[1];
			run_instr(s_type(12'd8, 5'd1, 5'd2, 3'b011), 1'b1, regs_m[2] + 64'd8, 5'd0,
				64'd0, pc_m + 64'd4);
			do_alu(i_type(12'd0, 5'd0, 3'b000, 5'd1, op_imm), 5'd1, 64'd0);
			run_instr(i_type(12'd8, 5'd2, 3'b011, 5'd3, op_load), 1'b1, regs_m[2] + 64'd8,
				5'd3, stored, pc_m + 64'd4);
			read_reg(5'd3);
		end
	endtask

	task automatic branch_jump_flow();
		logic [31:0] r;
		logic [12:0] boff;
		logic [20:0] joff;
		xlen_t       tgt;
		for (int n = 0; n < 4; n++) begin
			load_val(5'd1, $random(seed));
			do_alu(i_type(12'd0, 5'd1, 3'b000, 5'd2, op_imm), 5'd2, regs_m[1]);
			load_val(5'd3, $random(seed));
			r    = $random(seed);
			boff = {r[12:1], 1'b0};
			branch_step(3'b000, 5'd1, 5'd2, boff, regs_m[1] == regs_m[2]);
			branch_step(3'b000, 5'd1, 5'd3, boff, regs_m[1] == regs_m[3]);
			branch_step(3'b001, 5'd1, 5'd3, boff, regs_m[1] != regs_m[3]);
			branch_step(3'b001, 5'd1, 5'd2, boff, regs_m[1] != regs_m[2]);
			branch_step(3'b100, 5'd1, 5'd3, boff, $signed(regs_m[1]) < $signed(regs_m[3]));
			branch_step(3'b100, 5'd3, 5'd1, boff, $signed(regs_m[3]) < $signed(regs_m[1]));
			joff = {r[31:12], 1'b0};
			tgt  = pc_m + {{43{joff[20]}}, joff};
			run_instr(j_type(joff, 5'd5), 1'b1, tgt, 5'd5, pc_m + 64'd4, tgt);
			read_reg(5'd5); // Link value
		end
	endtask

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		inst  = 32'h0000_007f;
		seed  = 53;
		pc_m  = reset_pc;
		for (int i = 0; i < 32; i++) begin
			regs_m[i] = '0;
		end
		reset_and_release();
		pc_sequence();
		add_sub_ops();
		logic_shift_ops();
		load_store_pair();
		branch_jump_flow();
		wait_fall();
		#40;
		check("pc_out", pc_out, pc_m); // Next PC of the last instruction
		$display("All tests passed");
		$finish;
	end

endmodule
